//--- run_sim.sh
#!/usr/bin/env bash
# builds the core testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_core -f sim.f -o Vtb_core; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_core > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error status"
  exit 1
fi

cat "$LOG"
if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- sim.f
+incdir+src
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/regfile.sv
src/execute_stage.sv
src/writeback_stage.sv
src/hazard_control.sv
src/mycpu_core_top.sv
testbench/core_properties.sv
testbench/tb_core.sv

//--- src/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define DATA_W      32
`define REG_ADDR_W  5
`define RESET_PC    32'hbfc0_0000

// primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_ADDIU    6'b001001
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011

// function field of SPECIAL
`define FN_SLL      6'b000000
`define FN_ADDU     6'b100001
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

`endif

//--- src/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

  typedef logic [`DATA_W-1:0]     word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [3:0]             byte_en_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_LUI
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

  typedef struct packed {
    logic  valid;
    word_t pc;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     opr1;
    word_t     opr2;     // rt value, shift amount or extended immediate
    alu_op_e   alu_op;
    mem_op_e   mem_op;
    word_t     sdata;
    logic      we;
    reg_addr_t dest;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     result;
    mem_op_e   mem_op;
    logic      we;
    reg_addr_t dest;
  } ex_wb_t;

  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } rf_write_t;

endpackage

//--- src/decode_stage.sv
`include "cpu_defs.svh"

module decode_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      freeze_i,
  input  logic      hold_i,
  input  logic      bubble_i,
  input  if_id_t    if_id_i,
  input  word_t     inst_i,
  input  word_t     rs_data_i,
  input  word_t     rt_data_i,
  input  rf_write_t fwd_i,
  output reg_addr_t rs_addr_o,
  output reg_addr_t rt_addr_o,
  output logic      rs_use_o,
  output logic      rt_use_o,
  output id_ex_t    id_ex_o
);

  word_t     inst_q;
  logic      keep_q;
  word_t     inst;
  logic [5:0] op;
  logic [5:0] fn;
  word_t     imm_s;
  word_t     imm_z;
  word_t     rs_val;
  word_t     rt_val;
  logic      known;
  logic      rs_use;
  logic      rt_use;
  id_ex_t    nxt;
  id_ex_t    id_ex_q;

  // fetch data lasts one cycle, replay the saved word after a freeze or hold
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      keep_q <= 1'b0;
    end else begin
      keep_q <= freeze_i | hold_i;
    end
  end

  always_ff @(posedge clk) begin
    if (freeze_i || hold_i) begin
      inst_q <= inst;
    end
  end

  assign inst      = keep_q ? inst_q : inst_i;
  assign op        = inst[31:26];
  assign fn        = inst[5:0];
  assign rs_addr_o = inst[25:21];
  assign rt_addr_o = inst[20:16];
  assign imm_s     = word_t'($signed(inst[15:0]));
  assign imm_z     = word_t'(inst[15:0]);

  // execute result wins over the register file
  assign rs_val = (fwd_i.we && fwd_i.addr == rs_addr_o && rs_addr_o != '0) ?
                  fwd_i.data : rs_data_i;
  assign rt_val = (fwd_i.we && fwd_i.addr == rt_addr_o && rt_addr_o != '0) ?
                  fwd_i.data : rt_data_i;

  always_comb begin
    nxt        = '0;
    nxt.pc     = if_id_i.pc;
    nxt.opr1   = rs_val;
    nxt.opr2   = imm_s;
    nxt.alu_op = ALU_ADD;
    nxt.mem_op = MEM_NONE;
    nxt.sdata  = rt_val;
    nxt.dest   = rt_addr_o;
    known      = 1'b1;
    rs_use     = 1'b1;
    rt_use     = 1'b0;
    case (op)
      `OP_SPECIAL: begin
        nxt.opr2 = rt_val;
        nxt.dest = inst[15:11];
        nxt.we   = 1'b1;
        rt_use   = 1'b1;
        case (fn)
          `FN_ADDU: nxt.alu_op = ALU_ADD;
          `FN_SUBU: nxt.alu_op = ALU_SUB;
          `FN_AND:  nxt.alu_op = ALU_AND;
          `FN_OR:   nxt.alu_op = ALU_OR;
          `FN_XOR:  nxt.alu_op = ALU_XOR;
          `FN_SLT:  nxt.alu_op = ALU_SLT;
          `FN_SLTU: nxt.alu_op = ALU_SLTU;
          `FN_SLL: begin
            nxt.alu_op = ALU_SLL;
            nxt.opr1   = rt_val;
            nxt.opr2   = word_t'(inst[10:6]);
            rs_use     = 1'b0;
          end
          default:  known = 1'b0;
        endcase
      end
      `OP_ADDIU: nxt.we = 1'b1;
      `OP_ANDI: begin
        nxt.alu_op = ALU_AND;
        nxt.opr2   = imm_z;
        nxt.we     = 1'b1;
      end
      `OP_ORI: begin
        nxt.alu_op = ALU_OR;
        nxt.opr2   = imm_z;
        nxt.we     = 1'b1;
      end
      `OP_LUI: begin
        nxt.alu_op = ALU_LUI;
        nxt.opr2   = imm_z;
        nxt.we     = 1'b1;
        rs_use     = 1'b0;
      end
      `OP_LW: begin
        nxt.mem_op = MEM_LOAD;
        nxt.we     = 1'b1;
      end
      `OP_SW: begin
        nxt.mem_op = MEM_STORE;
        rt_use     = 1'b1;
      end
      default: known = 1'b0;
    endcase
    nxt.valid = if_id_i.valid & known;
    nxt.we    = nxt.we & nxt.valid & (nxt.dest != '0); // $0 never written
  end

  assign rs_use_o = rs_use & nxt.valid;
  assign rt_use_o = rt_use & nxt.valid;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_q <= '0;
    end else if (!freeze_i) begin
      id_ex_q <= bubble_i ? '0 : nxt;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

//--- src/execute_stage.sv
module execute_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      freeze_i,
  input  id_ex_t    id_ex_i,
  output logic      data_en_o,
  output byte_en_t  data_wen_o,
  output word_t     data_addr_o,
  output word_t     data_wdata_o,
  output rf_write_t fwd_o,
  output logic      fwd_load_o,
  output ex_wb_t    ex_wb_o
);

  word_t  a;
  word_t  b;
  word_t  result;
  logic   is_mem;
  ex_wb_t ex_wb_q;

  assign a = id_ex_i.opr1;
  assign b = id_ex_i.opr2;

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:  result = a + b;   // also load/store address
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLT:  result = word_t'($signed(a) < $signed(b));
      ALU_SLTU: result = word_t'(a < b);
      ALU_SLL:  result = a << b[4:0];
      ALU_LUI:  result = {b[15:0], 16'h0000};
      default:  result = '0;
    endcase
  end

  assign is_mem       = id_ex_i.valid && id_ex_i.mem_op != MEM_NONE;
  assign data_en_o    = is_mem;
  assign data_wen_o   = (is_mem && id_ex_i.mem_op == MEM_STORE) ? '1 : '0;
  assign data_addr_o  = result;
  assign data_wdata_o = id_ex_i.sdata;

  // load result is only an address here, hazard_control stalls on it
  assign fwd_o.we   = id_ex_i.valid & id_ex_i.we;
  assign fwd_o.addr = id_ex_i.dest;
  assign fwd_o.data = result;
  assign fwd_load_o = id_ex_i.valid && id_ex_i.mem_op == MEM_LOAD;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_wb_q <= '0;
    end else if (!freeze_i) begin
      ex_wb_q.valid  <= id_ex_i.valid;
      ex_wb_q.pc     <= id_ex_i.pc;
      ex_wb_q.result <= result;
      ex_wb_q.mem_op <= id_ex_i.mem_op;
      ex_wb_q.we     <= id_ex_i.we;
      ex_wb_q.dest   <= id_ex_i.dest;
    end
  end

  assign ex_wb_o = ex_wb_q;

endmodule

//--- src/fetch_stage.sv
`include "cpu_defs.svh"

module fetch_stage import cpu_pkg::*; (
  input  logic   clk,
  input  logic   rst_n_i,
  input  logic   freeze_i,
  input  logic   hold_i,
  output logic   inst_en_o,
  output word_t  inst_addr_o,
  output if_id_t if_id_o
);

  word_t  pc_q;
  if_id_t if_id_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q    <= `RESET_PC;
      if_id_q <= '0;
    end else if (!freeze_i && !hold_i) begin
      pc_q          <= pc_q + 32'd4;
      if_id_q.valid <= 1'b1;   // word for pc_q arrives next cycle
      if_id_q.pc    <= pc_q;
    end
  end

  // always requesting, a stall simply holds the address
  assign inst_en_o   = 1'b1;
  assign inst_addr_o = pc_q;
  assign if_id_o     = if_id_q;

endmodule

//--- src/hazard_control.sv
module hazard_control import cpu_pkg::*; (
  input  logic      imem_stall_i,
  input  logic      dmem_stall_i,
  input  reg_addr_t rs_addr_i,
  input  reg_addr_t rt_addr_i,
  input  logic      rs_use_i,
  input  logic      rt_use_i,
  input  logic      ex_load_i,
  input  reg_addr_t ex_dest_i,
  output logic      freeze_o,
  output logic      hold_o,
  output logic      bubble_o
);

  logic load_use;

  assign freeze_o = imem_stall_i | dmem_stall_i;

  assign load_use = ex_load_i && ex_dest_i != '0 &&
                    ((rs_use_i && rs_addr_i == ex_dest_i) ||
                     (rt_use_i && rt_addr_i == ex_dest_i));

  // freeze takes priority, the hold then happens once it clears
  assign hold_o   = load_use & ~freeze_o;
  assign bubble_o = hold_o;

endmodule

//--- src/mycpu_core_top.sv
module mycpu_core_top import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  // rdata returns one cycle after an unstalled instruction request
  output logic      inst_en_o,
  output word_t     inst_addr_o,
  input  word_t     inst_rdata_i,
  input  logic      imem_stall_i,
  // a data request counts only in a cycle with neither stall high
  output logic      data_en_o,
  output byte_en_t  data_wen_o,
  output word_t     data_addr_o,
  output word_t     data_wdata_o,
  input  word_t     data_rdata_i,
  input  logic      dmem_stall_i,
  output word_t     debug_wb_pc,
  output byte_en_t  debug_wb_rf_wen,
  output reg_addr_t debug_wb_rf_wnum,
  output word_t     debug_wb_rf_wdata
);

  if_id_t    if_id;
  id_ex_t    id_ex;
  ex_wb_t    ex_wb;
  rf_write_t rf_wr;
  rf_write_t ex_fwd;
  logic      ex_load;
  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  logic      rs_use;
  logic      rt_use;
  word_t     rs_data;
  word_t     rt_data;
  logic      freeze;
  logic      hold;
  logic      bubble;

  fetch_stage u_fetch (
    .clk, .rst_n_i, .freeze_i(freeze), .hold_i(hold),
    .inst_en_o, .inst_addr_o, .if_id_o(if_id)
  );

  decode_stage u_decode (
    .clk, .rst_n_i, .freeze_i(freeze), .hold_i(hold), .bubble_i(bubble),
    .if_id_i(if_id), .inst_i(inst_rdata_i),
    .rs_data_i(rs_data), .rt_data_i(rt_data), .fwd_i(ex_fwd),
    .rs_addr_o(rs_addr), .rt_addr_o(rt_addr),
    .rs_use_o(rs_use), .rt_use_o(rt_use), .id_ex_o(id_ex)
  );

  regfile u_regfile (
    .clk, .rst_n_i, .raddr1_i(rs_addr), .raddr2_i(rt_addr),
    .rdata1_o(rs_data), .rdata2_o(rt_data), .wr_i(rf_wr)
  );

  execute_stage u_execute (
    .clk, .rst_n_i, .freeze_i(freeze), .id_ex_i(id_ex),
    .data_en_o, .data_wen_o, .data_addr_o, .data_wdata_o,
    .fwd_o(ex_fwd), .fwd_load_o(ex_load), .ex_wb_o(ex_wb)
  );

  writeback_stage u_writeback (
    .clk, .rst_n_i, .freeze_i(freeze), .ex_wb_i(ex_wb), .data_rdata_i,
    .rf_wr_o(rf_wr), .debug_wb_pc, .debug_wb_rf_wen,
    .debug_wb_rf_wnum, .debug_wb_rf_wdata
  );

  hazard_control u_hazard (
    .imem_stall_i, .dmem_stall_i,
    .rs_addr_i(rs_addr), .rt_addr_i(rt_addr), .rs_use_i(rs_use), .rt_use_i(rt_use),
    .ex_load_i(ex_load), .ex_dest_i(ex_fwd.addr),
    .freeze_o(freeze), .hold_o(hold), .bubble_o(bubble)
  );

endmodule

//--- src/regfile.sv
module regfile import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  reg_addr_t raddr1_i,
  input  reg_addr_t raddr2_i,
  output word_t     rdata1_o,
  output word_t     rdata2_o,
  input  rf_write_t wr_i
);

  word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_i.we && wr_i.addr != '0) begin
      regs[wr_i.addr] <= wr_i.data;
    end
  end

  // same-cycle write shows through to the reader
  function automatic word_t read_port(reg_addr_t a);
    word_t v;
    v = (a == '0) ? '0 : regs[a];
    if (wr_i.we && wr_i.addr == a && a != '0) begin
      v = wr_i.data;
    end
    return v;
  endfunction

  always_comb begin
    rdata1_o = read_port(raddr1_i);
    rdata2_o = read_port(raddr2_i);
  end

endmodule

//--- src/writeback_stage.sv
module writeback_stage import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      freeze_i,
  input  ex_wb_t    ex_wb_i,
  input  word_t     data_rdata_i,
  output rf_write_t rf_wr_o,
  output word_t     debug_wb_pc,
  output byte_en_t  debug_wb_rf_wen,
  output reg_addr_t debug_wb_rf_wnum,
  output word_t     debug_wb_rf_wdata
);

  logic  keep_q;
  word_t load_q;
  word_t load_data;

  // read data is valid only in the first cycle, keep it through a freeze
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      keep_q <= 1'b0;
    end else begin
      keep_q <= freeze_i;
    end
  end

  always_ff @(posedge clk) begin
    if (freeze_i) begin
      load_q <= load_data;
    end
  end

  assign load_data = keep_q ? load_q : data_rdata_i;

  assign rf_wr_o.we   = ex_wb_i.valid & ex_wb_i.we & ~freeze_i; // retire once, unfrozen
  assign rf_wr_o.addr = ex_wb_i.dest;
  assign rf_wr_o.data = (ex_wb_i.mem_op == MEM_LOAD) ? load_data : ex_wb_i.result;

  assign debug_wb_pc       = ex_wb_i.pc;
  assign debug_wb_rf_wen   = {4{rf_wr_o.we}};
  assign debug_wb_rf_wnum  = rf_wr_o.addr;
  assign debug_wb_rf_wdata = rf_wr_o.data;

endmodule

//--- testbench/core_properties.sv
module core_properties (
  input logic        clk,
  input logic        rst_n_i,
  input logic        imem_stall_i,
  input logic        dmem_stall_i,
  input logic        data_en_o,
  input logic [3:0]  data_wen_o,
  input logic [31:0] inst_addr_o,
  input logic [31:0] data_addr_o,
  input logic [3:0]  debug_wb_rf_wen
);

  wen_needs_en: assert property (@(posedge clk) disable iff (!rst_n_i)
    (data_wen_o != 4'h0) |-> data_en_o)
    else $error("data_wen_o set without data_en_o");

  trace_wen_form: assert property (@(posedge clk) disable iff (!rst_n_i)
    (debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf))
    else $error("debug_wb_rf_wen is neither all zeros nor all ones");

  // a stalled request keeps its address
  addr_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    (imem_stall_i || dmem_stall_i) |=> ($stable(inst_addr_o) && $stable(data_addr_o)))
    else $error("address changed under a stall");

endmodule

bind mycpu_core_top core_properties u_props (.*);

//--- testbench/tb_core.sv
`include "cpu_defs.svh"

module tb_core;

  logic        clk;
  logic        rst_n;
  logic        inst_en;
  logic [31:0] inst_addr;
  logic [31:0] inst_rdata;
  logic        imem_stall;
  logic        data_en;
  logic [3:0]  data_wen;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic [31:0] data_rdata;
  logic        dmem_stall;
  logic [31:0] dbg_pc;
  logic [3:0]  dbg_wen;
  logic [4:0]  dbg_wnum;
  logic [31:0] dbg_wdata;

  logic [31:0] rom [0:255];
  logic [31:0] ram [0:255];
  logic [31:0] gold_rf [0:31];
  logic [31:0] gold_mem [0:255];
  logic [31:0] exp_pc[$];
  logic [4:0]  exp_num[$];
  logic [31:0] exp_data[$];
  int          prog_len;
  int          exp_total;
  int          retired;
  int          errors;
  int          checks;
  int          tests;
  logic        stall_on;

  mycpu_core_top DUT (
    .clk(clk), .rst_n_i(rst_n),
    .inst_en_o(inst_en), .inst_addr_o(inst_addr), .inst_rdata_i(inst_rdata),
    .imem_stall_i(imem_stall),
    .data_en_o(data_en), .data_wen_o(data_wen), .data_addr_o(data_addr),
    .data_wdata_o(data_wdata), .data_rdata_i(data_rdata), .dmem_stall_i(dmem_stall),
    .debug_wb_pc(dbg_pc), .debug_wb_rf_wen(dbg_wen),
    .debug_wb_rf_wnum(dbg_wnum), .debug_wb_rf_wdata(dbg_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] fill_word(input int i);
    return 32'h5a3c_0000 ^ (i * 32'h0101_0107) ^ (i << 24);
  endfunction

  // memories answer one cycle after a request taken with no stall high
  always @(posedge clk) begin
    if (!imem_stall && !dmem_stall) begin
      if (inst_en) begin
        inst_rdata <= (inst_addr - `RESET_PC < 32'd1024) ? rom[inst_addr[9:2]] : 32'h0;
      end
      if (data_en) begin
        if (data_wen != 4'h0) ram[data_addr[9:2]] <= data_wdata;
        else data_rdata <= ram[data_addr[9:2]];
      end
    end
  end

  always @(posedge clk) begin
    if (stall_on) begin
      imem_stall <= ($urandom % 4) == 0;
      dmem_stall <= ($urandom % 5) == 0;
    end else begin
      imem_stall <= 1'b0;
      dmem_stall <= 1'b0;
    end
  end

  // trace is stable by the falling edge
  always @(negedge clk) begin
    if (rst_n && dbg_wen != 4'h0) begin
      retired++;
      if (exp_pc.size() == 0) begin
        $display("unexpected register write from pc %h at t=%0t", dbg_pc, $time);
        errors++;
      end else begin
        check_val("debug_wb_rf_wen", {28'h0, dbg_wen}, 32'hf);
        check_val("debug_wb_pc", dbg_pc, exp_pc.pop_front());
        check_val("debug_wb_rf_wnum", {27'h0, dbg_wnum}, {27'h0, exp_num.pop_front()});
        check_val("debug_wb_rf_wdata", dbg_wdata, exp_data.pop_front());
      end
    end
  end

  function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt);
    return {`OP_SPECIAL, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] sll(input logic [4:0] rd, input logic [4:0] rt,
                                      input logic [4:0] sa);
    return {`OP_SPECIAL, 5'd0, rt, rd, sa, `FN_SLL};
  endfunction

  function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // place one instruction and run it on the reference model
  task automatic emit(input logic [31:0] w);
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  dst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_s;
    logic [31:0] imm_z;
    logic [31:0] ea;
    logic [31:0] v;
    logic        wr;
    rom[prog_len] = w;
    rs = w[25:21];
    rt = w[20:16];
    a = gold_rf[rs];
    b = gold_rf[rt];
    imm_s = {{16{w[15]}}, w[15:0]};
    imm_z = {16'h0, w[15:0]};
    ea = a + imm_s;
    dst = rt;
    wr = 1'b1;
    v = 32'h0;
    case (w[31:26])
      `OP_SPECIAL: begin
        dst = w[15:11];
        case (w[5:0])
          `FN_ADDU: v = a + b;
          `FN_SUBU: v = a - b;
          `FN_AND:  v = a & b;
          `FN_OR:   v = a | b;
          `FN_XOR:  v = a ^ b;
          `FN_SLT:  v = {31'h0, $signed(a) < $signed(b)};
          `FN_SLTU: v = {31'h0, a < b};
          `FN_SLL:  v = b << w[10:6];
          default:  wr = 1'b0;
        endcase
      end
      `OP_ADDIU: v = a + imm_s;
      `OP_ANDI:  v = a & imm_z;
      `OP_ORI:   v = a | imm_z;
      `OP_LUI:   v = {w[15:0], 16'h0};
      `OP_LW:    v = gold_mem[ea[9:2]];
      `OP_SW: begin
        gold_mem[ea[9:2]] = b;
        wr = 1'b0;
      end
      default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0) begin
      gold_rf[dst] = v;
      exp_pc.push_back(`RESET_PC + 32'(prog_len * 4));
      exp_num.push_back(dst);
      exp_data.push_back(v);
      exp_total++;
    end
    prog_len++;
  endtask

  task automatic prepare();
    for (int i = 0; i < 256; i++) begin
      rom[i] = 32'h0;
      ram[i] = fill_word(i);
      gold_mem[i] = fill_word(i);
    end
    for (int i = 0; i < 32; i++) gold_rf[i] = 32'h0;
    exp_pc.delete();
    exp_num.delete();
    exp_data.delete();
    prog_len = 0;
    exp_total = 0;
    retired = 0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    @(negedge clk);
    check_val("inst_en_o", {31'h0, inst_en}, 32'h1);
    check_val("data_en_o", {31'h0, data_en}, 32'h0);
    check_val("data_wen_o", {28'h0, data_wen}, 32'h0);
    check_val("debug_wb_rf_wen", {28'h0, dbg_wen}, 32'h0);
    @(posedge clk);
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_val("inst_addr_o", inst_addr, `RESET_PC);
  endtask

  task automatic run_program(input string name);
    int err_start;
    int cycles;
    err_start = errors;
    emit(itype(`OP_ADDIU, 5'd30, 5'd0, 16'h07ff)); // end marker
    apply_reset();
    cycles = 0;
    while (retired < exp_total && cycles < 3000) begin
      @(posedge clk);
      cycles++;
    end
    if (retired < exp_total) begin
      $display("timeout in %s: only %0d of %0d writes retired", name, retired, exp_total);
      errors++;
    end
    stall_on = 1'b0;
    repeat (12) @(posedge clk);
    check_val("retired_count", 32'(retired), 32'(exp_total));
    for (int i = 0; i < 256; i++) begin
      check_val($sformatf("ram[%0d]", i), ram[i], gold_mem[i]);
    end
    tests++;
    $display("test %s: %0d writes, %0d errors", name, exp_total, errors - err_start);
  endtask

  task automatic reset_sequence();
    prepare();
    run_program("reset");
  endtask

  task automatic alu_ops();
    prepare();
    emit(itype(`OP_LUI, 5'd1, 5'd0, 16'h8001));
    emit(itype(`OP_ORI, 5'd1, 5'd1, 16'h2345));
    emit(itype(`OP_ADDIU, 5'd2, 5'd0, 16'hfffb));
    emit(itype(`OP_ADDIU, 5'd3, 5'd0, 16'h0007));
    emit(rtype(`FN_ADDU, 5'd4, 5'd1, 5'd2));
    emit(rtype(`FN_SUBU, 5'd5, 5'd3, 5'd2));
    emit(rtype(`FN_AND, 5'd6, 5'd1, 5'd2));
    emit(rtype(`FN_OR, 5'd7, 5'd1, 5'd3));
    emit(rtype(`FN_XOR, 5'd8, 5'd1, 5'd2));
    emit(rtype(`FN_SLT, 5'd9, 5'd2, 5'd3));
    emit(rtype(`FN_SLTU, 5'd10, 5'd2, 5'd3));
    emit(sll(5'd11, 5'd3, 5'd5));
    emit(itype(`OP_ANDI, 5'd12, 5'd1, 16'hf0f0));
    emit(itype(`OP_ORI, 5'd13, 5'd2, 16'h00ff));
    emit(itype(`OP_ADDIU, 5'd0, 5'd3, 16'h0009)); // $0 stays zero
    emit(rtype(`FN_ADDU, 5'd14, 5'd0, 5'd3));
    emit(rtype(`FN_OR, 5'd15, 5'd0, 5'd0));
    run_program("alu");
  endtask

  task automatic forward_paths();
    prepare();
    emit(itype(`OP_ADDIU, 5'd1, 5'd0, 16'h0003));
    emit(rtype(`FN_ADDU, 5'd2, 5'd1, 5'd1));
    emit(rtype(`FN_ADDU, 5'd3, 5'd2, 5'd1));
    emit(itype(`OP_ADDIU, 5'd4, 5'd0, 16'h000a));
    emit(itype(`OP_ADDIU, 5'd5, 5'd0, 16'h0001));
    emit(rtype(`FN_SUBU, 5'd6, 5'd4, 5'd5));
    emit(itype(`OP_ADDIU, 5'd7, 5'd0, 16'h0055));
    emit(itype(`OP_ORI, 5'd8, 5'd0, 16'h0001));
    emit(itype(`OP_ORI, 5'd9, 5'd0, 16'h0002));
    emit(rtype(`FN_XOR, 5'd10, 5'd7, 5'd9));
    emit(sll(5'd11, 5'd10, 5'd3));
    emit(rtype(`FN_SLT, 5'd12, 5'd11, 5'd10));
    run_program("forward");
  endtask

  task automatic load_store();
    prepare();
    emit(itype(`OP_ORI, 5'd1, 5'd0, 16'h0100));
    emit(itype(`OP_ADDIU, 5'd2, 5'd0, 16'h1234));
    emit(itype(`OP_SW, 5'd2, 5'd1, 16'h0000));
    emit(itype(`OP_LW, 5'd3, 5'd1, 16'h0000));
    emit(rtype(`FN_ADDU, 5'd4, 5'd3, 5'd3));  // load-use
    emit(itype(`OP_LW, 5'd5, 5'd1, 16'h0008));
    emit(itype(`OP_SW, 5'd4, 5'd1, 16'h0008));
    emit(itype(`OP_LW, 5'd6, 5'd1, 16'h0008));
    emit(itype(`OP_SW, 5'd6, 5'd1, 16'hfffc));
    emit(itype(`OP_LW, 5'd7, 5'd1, 16'hfffc));
    emit(rtype(`FN_SUBU, 5'd8, 5'd7, 5'd5));
    emit(itype(`OP_LW, 5'd9, 5'd1, 16'h0000));
    emit(itype(`OP_SW, 5'd9, 5'd1, 16'h000c));  // store data from the load
    emit(itype(`OP_LW, 5'd10, 5'd1, 16'h000c));
    run_program("memory");
  endtask

  task automatic random_freeze();
    logic [4:0] rd;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [15:0] imm;
    prepare();
    emit(itype(`OP_ORI, 5'd8, 5'd0, 16'h0200));  // base register r8 is never overwritten
    for (int i = 1; i < 8; i++) begin
      emit(itype(`OP_ADDIU, 5'(i), 5'd0, 16'($urandom)));
    end
    for (int i = 0; i < 48; i++) begin
      rd = 5'(1 + $urandom % 7);
      rs = 5'($urandom % 9);
      rt = 5'($urandom % 9);
      imm = 16'($urandom);
      case ($urandom % 14)
        0: emit(rtype(`FN_ADDU, rd, rs, rt));
        1: emit(rtype(`FN_SUBU, rd, rs, rt));
        2: emit(rtype(`FN_AND, rd, rs, rt));
        3: emit(rtype(`FN_OR, rd, rs, rt));
        4: emit(rtype(`FN_XOR, rd, rs, rt));
        5: emit(rtype(`FN_SLT, rd, rs, rt));
        6: emit(rtype(`FN_SLTU, rd, rs, rt));
        7: emit(sll(rd, rt, imm[4:0]));
        8: emit(itype(`OP_ADDIU, rd, rs, imm));
        9: emit(itype(`OP_ANDI, rd, rs, imm));
        10: emit(itype(`OP_ORI, rd, rs, imm));
        11: emit(itype(`OP_LUI, rd, 5'd0, imm));
        12: emit(itype(`OP_LW, rd, 5'd8, {10'h0, imm[3:0], 2'b00}));
        default: emit(itype(`OP_SW, rt, 5'd8, {10'h0, imm[3:0], 2'b00}));
      endcase
    end
    stall_on = 1'b1;
    run_program("freeze");
  endtask

  initial begin
    rst_n = 1'b0;
    inst_rdata = 32'h0;
    data_rdata = 32'h0;
    imem_stall = 1'b0;
    dmem_stall = 1'b0;
    stall_on = 1'b0;
    errors = 0;
    checks = 0;
    tests = 0;
    void'($urandom(32'h7951_fb7f));
    reset_sequence();
    alu_ops();
    forward_paths();
    load_store();
    random_freeze();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #400000;
    $display("simulation did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
